// File: design/multdiv_pkg.sv
package multdiv_pkg;

	// operand and result width
	localparam int data_width = 32;

	// radix-4 Booth retires two multiplier bits per step
	localparam int mult_steps = data_width / 2;

	// restoring division produces one quotient bit per step
	localparam int div_steps = data_width;

	// sized for the longer of the two step counts
	localparam int count_width = $clog2(div_steps);

	// upper partial product with two guard bits
	localparam int upper_width = data_width + 2;

	// guarded upper half, multiplier, extra low Booth bit
	localparam int mult_reg_width = upper_width + data_width + 1;

	// one Booth step applied to the upper half
	typedef enum logic [2:0] {
		pass   = 3'd0,
		add_m  = 3'd1,
		add_2m = 3'd2,
		sub_m  = 3'd3,
		sub_2m = 3'd4
	} booth_op_t;

	// multiply: a is the multiplicand, b the multiplier
	// divide: a is the dividend, b the divisor
	typedef struct packed {
		logic signed [data_width-1:0] a;
		logic signed [data_width-1:0] b;
	} md_operands_t;

	// result is only meaningful while ready is high
	typedef struct packed {
		logic [data_width-1:0] result;
		logic                  exception;
		logic                  ready;
	} md_result_t;

endpackage

// File: design/booth_step.sv
`timescale 1ns/1ns

module booth_step (
	input  logic [2:0]                                 bits,
	input  logic signed [multdiv_pkg::upper_width-1:0] upper,
	input  logic signed [multdiv_pkg::data_width-1:0]  multiplicand,
	output logic [multdiv_pkg::upper_width-1:0]        next_upper,
	output multdiv_pkg::booth_op_t                     op
);
	import multdiv_pkg::*;

	logic signed [upper_width-1:0] m_single;
	logic signed [upper_width-1:0] m_double;

	// multiplicand sign extended into the guarded width
	assign m_single = {{(upper_width - data_width){multiplicand[data_width-1]}}, multiplicand};

	// double of the multiplicand by a one bit left shift
	assign m_double = m_single <<< 1;

	// triplet is {b[i+1], b[i], b[i-1]}
	always_comb begin
		case (bits)
			3'b000: op = pass;
			3'b001: op = add_m;
			3'b010: op = add_m;
			3'b011: op = add_2m;
			3'b100: op = sub_2m;
			3'b101: op = sub_m;
			3'b110: op = sub_m;
			3'b111: op = pass;
			default: op = pass;
		endcase
	end

	// two guard bits keep every sum in range
	always_comb begin
		case (op)
			add_m: begin
				next_upper = upper + m_single;
			end
			add_2m: begin
				next_upper = upper + m_double;
			end
			sub_m: begin
				next_upper = upper - m_single;
			end
			sub_2m: begin
				next_upper = upper - m_double;
			end
			default: begin
				next_upper = upper;
			end
		endcase
	end

endmodule

// File: design/mult.sv
`timescale 1ns/1ns

module mult (
	input  logic                      clock,
	input  logic                      rst,
	input  logic                      start,
	input  multdiv_pkg::md_operands_t operands,
	output multdiv_pkg::md_result_t   res
);
	import multdiv_pkg::*;

	// {upper half, multiplier, extra low bit}
	logic signed [mult_reg_width-1:0] work;
	logic signed [mult_reg_width-1:0] work_next;
	logic signed [data_width-1:0]     multiplicand;
	logic [upper_width-1:0]           upper_cur;
	logic [upper_width-1:0]           upper_sum;
	logic [count_width-1:0]           count;
	logic                             busy;
	logic                             last_step;
	logic [data_width:0]              high_bits;
	logic                             overflow;
	md_result_t                       res_q;

	assign upper_cur = work[mult_reg_width-1 -: upper_width];

	booth_step booth_unit (
		.bits        (work[2:0]),
		.upper       (upper_cur),
		.multiplicand(multiplicand),
		.next_upper  (upper_sum),
		.op          ()
	);

	always_comb begin
		// arithmetic shift by two retires one Booth digit
		work_next = $signed({upper_sum, work[data_width:0]}) >>> 2;

		// product bits 63 down to 31
		high_bits = work_next[2*data_width:data_width];

		// product fits in 32 bits only if these all agree with the sign
		overflow = !((&high_bits) || !(|high_bits));

		last_step = (count == count_width'(mult_steps - 1));
	end

	// operand capture and the shifting product register
	always_ff @(posedge clock) begin
		if (start) begin
			multiplicand <= operands.a;
			work <= {{upper_width{1'b0}}, operands.b, 1'b0};
		end else if (busy) begin
			work <= work_next;
		end
	end

	// step counter and completion
	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
			count <= '0;
			res_q <= '0;
		end else if (start) begin
			// a strobe while busy simply restarts the count
			busy <= 1'b1;
			count <= '0;
			res_q.ready <= 1'b0;
		end else if (busy) begin
			count <= count + 1'b1;
			if (last_step) begin
				busy <= 1'b0;
				res_q.result <= work_next[data_width:1];
				res_q.exception <= overflow;
				res_q.ready <= 1'b1;
			end
		end
	end

	assign res = res_q;

endmodule

// File: design/div.sv
`timescale 1ns/1ns

module div (
	input  logic                      clock,
	input  logic                      rst,
	input  logic                      start,
	input  multdiv_pkg::md_operands_t operands,
	output multdiv_pkg::md_result_t   res
);
	import multdiv_pkg::*;

	// partial remainder and quotient shift left together
	logic [data_width-1:0]  rem;
	logic [data_width-1:0]  quo;
	logic [data_width-1:0]  divisor_mag;
	logic                   quo_neg;
	logic                   div_zero;
	logic [count_width-1:0] count;
	logic                   busy;
	logic                   last_step;
	logic [data_width:0]    rem_shift;
	logic [data_width+1:0]  trial;
	logic [data_width-1:0]  rem_next;
	logic [data_width-1:0]  quo_next;
	logic [data_width-1:0]  quo_final;
	md_result_t             res_q;

	// the most negative input maps to 2^31, which still fits unsigned
	function automatic logic [data_width-1:0] magnitude(
		input logic signed [data_width-1:0] value
	);
		if (value[data_width-1]) begin
			magnitude = -value;
		end else begin
			magnitude = value;
		end
	endfunction

	always_comb begin
		// bring down the next dividend bit
		rem_shift = {rem, quo[data_width-1]};
		trial = {1'b0, rem_shift} - {2'b00, divisor_mag};

		// restore when the trial went negative
		if (trial[data_width+1]) begin
			rem_next = rem_shift[data_width-1:0];
			quo_next = {quo[data_width-2:0], 1'b0};
		end else begin
			rem_next = trial[data_width-1:0];
			quo_next = {quo[data_width-2:0], 1'b1};
		end

		// truncation toward zero, modulo 2^32
		if (quo_neg) begin
			quo_final = -quo_next;
		end else begin
			quo_final = quo_next;
		end

		last_step = (count == count_width'(div_steps - 1));
	end

	// operand capture and the working pair
	always_ff @(posedge clock) begin
		if (start) begin
			rem <= '0;
			quo <= magnitude(operands.a);
			divisor_mag <= magnitude(operands.b);
			quo_neg <= operands.a[data_width-1] ^ operands.b[data_width-1];
			div_zero <= (operands.b == '0);
		end else if (busy) begin
			rem <= rem_next;
			quo <= quo_next;
		end
	end

	// step counter and completion
	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
			count <= '0;
			res_q <= '0;
		end else if (start) begin
			busy <= 1'b1;
			count <= '0;
			res_q.ready <= 1'b0;
		end else if (busy) begin
			count <= count + 1'b1;
			if (last_step) begin
				busy <= 1'b0;
				// zero divisor returns zero and flags it
				if (div_zero) begin
					res_q.result <= '0;
				end else begin
					res_q.result <= quo_final;
				end
				res_q.exception <= div_zero;
				res_q.ready <= 1'b1;
			end
		end
	end

	assign res = res_q;

endmodule

// File: design/multdiv.sv
`timescale 1ns/1ns

module multdiv (
	input  logic                      clock,
	input  logic                      rst,
	input  logic                      ctrl_mult,
	input  logic                      ctrl_div,
	input  multdiv_pkg::md_operands_t operands,
	output multdiv_pkg::md_result_t   res
);
	import multdiv_pkg::*;

	md_result_t mult_res;
	md_result_t div_res;

	// which unit owns the output
	logic div_active;

	mult mult_unit (
		.clock   (clock),
		.rst     (rst),
		.start   (ctrl_mult),
		.operands(operands),
		.res     (mult_res)
	);

	div div_unit (
		.clock   (clock),
		.rst     (rst),
		.start   (ctrl_div),
		.operands(operands),
		.res     (div_res)
	);

	// last strobe wins, so the idle unit's stale ready stays hidden
	always_ff @(posedge clock) begin
		if (rst) begin
			div_active <= 1'b0;
		end else if (ctrl_div) begin
			div_active <= 1'b1;
		end else if (ctrl_mult) begin
			div_active <= 1'b0;
		end
	end

	// no added latency, just the select
	always_comb begin
		if (div_active) begin
			res = div_res;
		end else begin
			res = mult_res;
		end
	end

endmodule

// File: sim/multdiv_tb.sv
`timescale 1ns/1ns

module multdiv_tb;
	import multdiv_pkg::*;

	localparam logic [data_width-1:0] min_val = 32'h8000_0000;
	localparam logic [data_width-1:0] max_val = 32'h7fff_ffff;
	localparam int random_ops = 200;
	// directed, random and restart operations, each at most ~40 cycles
	localparam int timeout_cycles = 8 + (random_ops + 40) * 40;

	logic       clock;
	logic       rst;
	logic       ctrl_mult;
	logic       ctrl_div;
	md_operands_t operands;
	md_result_t   res;
	int         cycle_count;

	multdiv multdiv_inst (
		.clock    (clock),
		.rst      (rst),
		.ctrl_mult(ctrl_mult),
		.ctrl_div (ctrl_div),
		.operands (operands),
		.res      (res)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// one cycle strobe of the chosen kind
	task automatic strobe(input logic is_div, input logic [data_width-1:0] a,
			input logic [data_width-1:0] b);
		@(posedge clock);
		operands.a <= a;
		operands.b <= b;
		ctrl_div <= is_div;
		ctrl_mult <= !is_div;
		@(posedge clock);
		ctrl_mult <= 1'b0;
		ctrl_div <= 1'b0;
	endtask

	// ready is read half a cycle away from the updating edge
	task automatic wait_ready();
		@(negedge clock);
		while (!res.ready) begin
			@(negedge clock);
		end
	endtask

	task automatic run_op(input logic is_div, input logic [data_width-1:0] a,
			input logic [data_width-1:0] b);
		strobe(is_div, a, b);
		wait_ready();
		repeat ($urandom_range(0, 3)) @(posedge clock);
	endtask

	task automatic run_both(input logic [data_width-1:0] a, input logic [data_width-1:0] b);
		run_op(1'b0, a, b);
		run_op(1'b1, a, b);
	endtask

	// half small values so that fitting products show up often
	function automatic logic [data_width-1:0] random_operand();
		if ($urandom_range(0, 1) == 1) begin
			return data_width'($urandom_range(0, 200)) - 32'd100;
		end
		return $urandom;
	endfunction

	// first checker error or a stuck run ends everything here
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (multdiv_inst.checks.fail_count != 0) begin
			$display("Fail at %0t: %s", $time, multdiv_inst.checks.last_failure);
			$display("Verification failed");
			$fatal(1, "stopping on the first checker error");
		end else if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the DUT did not finish its operations within %0d cycles",
				timeout_cycles);
			$display("Verification failed");
			$fatal(1, "stopping on timeout");
		end
	end

	initial begin
		void'($urandom(2));
		rst = 1'b1;
		ctrl_mult = 1'b0;
		ctrl_div = 1'b0;
		operands = '0;
		cycle_count = 0;
		repeat (8) @(posedge clock);
		rst <= 1'b0;

		run_both(32'd0, 32'd0);
		run_both(32'd1, 32'd1);
		run_both(32'hffff_ffff, 32'hffff_ffff);
		run_both(32'd1, 32'hffff_ffff);
		run_both(min_val, 32'd1);
		run_both(max_val, 32'd1);
		run_both(max_val, max_val);
		run_both(min_val, min_val);
		run_both(min_val, 32'hffff_ffff);
		run_both(max_val, 32'd0);
		run_both(32'd12345, 32'd0);
		run_both(-32'sd7, 32'd2);
		run_both(32'd7, -32'sd2);
		run_both(32'd100, 32'd7);

		// restart while busy, same kind and then the other kind
		strobe(1'b0, 32'd1000, 32'd3);
		repeat (5) @(posedge clock);
		strobe(1'b0, -32'sd5, 32'd9);
		wait_ready();
		strobe(1'b1, 32'd99, 32'd4);
		repeat (10) @(posedge clock);
		strobe(1'b1, -32'sd99, 32'd5);
		wait_ready();
		strobe(1'b1, 32'd1, 32'd1);
		repeat (3) @(posedge clock);
		strobe(1'b0, 32'd6, 32'd7);
		wait_ready();

		for (int i = 0; i < random_ops; i++) begin
			run_op(1'($urandom_range(0, 1)), random_operand(), random_operand());
		end

		repeat (2) @(posedge clock);
		if (multdiv_inst.checks.fail_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("Fail at %0t: %s", $time, multdiv_inst.checks.last_failure);
			$display("Verification failed");
			$fatal(1, "checker errors at the end of the run");
		end
	end

endmodule

// File: sim/multdiv_asserts.sv
`timescale 1ns/1ns

module multdiv_asserts (
	input logic                      clock,
	input logic                      rst,
	input logic                      ctrl_mult,
	input logic                      ctrl_div,
	input multdiv_pkg::md_operands_t operands,
	input multdiv_pkg::md_result_t   res
);
	import multdiv_pkg::*;

	localparam longint max_s32 = 64'sd2147483647;
	localparam longint min_s32 = -64'sd2147483648;

	int                           fail_count = 0;
	string                        last_failure = "";
	logic                         started;
	logic                         kind_div;
	logic signed [data_width-1:0] a_q;
	logic signed [data_width-1:0] b_q;
	// cycles since the last strobe, saturating
	logic [6:0]                   elapsed;
	int                           latency;
	longint                       product;
	longint                       quotient;
	logic [data_width-1:0]        exp_result;
	logic                         exp_exc;

	task automatic note_failure(input string why);
		fail_count++;
		last_failure = why;
	endtask

	// the operation that the next ready belongs to
	always_ff @(posedge clock) begin
		if (rst) begin
			started <= 1'b0;
			kind_div <= 1'b0;
			elapsed <= '0;
		end else if (ctrl_mult || ctrl_div) begin
			started <= 1'b1;
			kind_div <= ctrl_div;
			a_q <= operands.a;
			b_q <= operands.b;
			elapsed <= 7'd1;
		end else if (elapsed != 7'h7f) begin
			elapsed <= elapsed + 1'b1;
		end
	end

	always_comb begin
		latency = kind_div ? div_steps : mult_steps;
		product = longint'(a_q) * longint'(b_q);
		quotient = 0;
		if (b_q != 0) begin
			quotient = longint'(a_q) / longint'(b_q);
		end
		if (kind_div) begin
			exp_result = quotient[data_width-1:0];
			exp_exc = (b_q == 0);
		end else begin
			exp_result = product[data_width-1:0];
			exp_exc = (product > max_s32) || (product < min_s32);
		end
	end

	strobes_exclusive: assert property (@(posedge clock) disable iff (rst)
		!(ctrl_mult && ctrl_div))
		else begin
			note_failure("ctrl_mult and ctrl_div high in the same cycle");
			$error("Fail at %0t: both strobes high", $time);
		end

	ready_cleared_by_reset: assert property (@(posedge clock) rst |=> !res.ready)
		else begin
			note_failure("res.ready high right after reset");
			$error("Fail at %0t: ready after reset", $time);
		end

	idle_not_ready: assert property (@(posedge clock) disable iff (rst)
		!started |-> !res.ready)
		else begin
			note_failure("res.ready high before any operation");
			$error("Fail at %0t: ready with no operation", $time);
		end

	low_while_running: assert property (@(posedge clock) disable iff (rst)
		(started && elapsed <= latency) |-> !res.ready)
		else begin
			note_failure("res.ready rose too early");
			$error("Fail at %0t: early ready, %0d cycles after strobe", $time, elapsed);
		end

	high_when_done: assert property (@(posedge clock) disable iff (rst)
		(started && elapsed > latency) |-> res.ready)
		else begin
			note_failure("res.ready missing after the expected latency");
			$error("Fail at %0t: no ready, %0d cycles after strobe", $time, elapsed);
		end

	result_matches: assert property (@(posedge clock) disable iff (rst)
		(started && res.ready) |-> (res.result == exp_result))
		else begin
			note_failure("res.result differs from the expected value");
			$error("Fail at %0t: result %h, expected %h", $time, res.result, exp_result);
		end

	exception_matches: assert property (@(posedge clock) disable iff (rst)
		(started && res.ready) |-> (res.exception == exp_exc))
		else begin
			note_failure("res.exception differs from the expected value");
			$error("Fail at %0t: exception %b, expected %b", $time, res.exception, exp_exc);
		end

endmodule

bind multdiv multdiv_asserts checks (
	.clock    (clock),
	.rst      (rst),
	.ctrl_mult(ctrl_mult),
	.ctrl_div (ctrl_div),
	.operands (operands),
	.res      (res)
);

// File: build.f
design/multdiv_pkg.sv
design/booth_step.sv
design/mult.sv
design/div.sv
design/multdiv.sv
sim/multdiv_tb.sv
sim/multdiv_asserts.sv
